/* hdl/dsp_cmd_decode.sv */
module dsp_cmd_decode
  import mcbsp_link_pkg::*;
(
  input  logic       mcbsp0_slaver_clkx,
  input  logic       cfg_rst,
  input  rx_word_t   rx,
  output logic       send_start,
  output step_t      send_step,
  output logic       part_syn_start,
  output logic       lose,
  output logic       dsp_start_send,
  output cmd_flags_t flags,
  output sync_arm_t  arm,
  output logic       tx_begin
);

  dsp_word_u w;
  logic      is_step;

  assign w = rx.word;

  // step n is AAAA_nnnn with n in 0..7
  assign is_step = (w.cmd.tag == CMD_STEP_TAG) &&
                   (w.cmd.code == {4{w.cmd.code[3:0]}}) &&
                   !w.cmd.code[3];

  //////////////////////////////
  // decode and pulse
  //////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      send_start     <= 1'b0;
      send_step      <= '0;
      part_syn_start <= 1'b0;
      lose           <= 1'b0;
      dsp_start_send <= 1'b0;
      flags          <= '0;
      arm            <= '0;
      tx_begin       <= 1'b0;
    end else begin
      // pulses default low, step and start_send hold
      send_start     <= 1'b0;
      part_syn_start <= 1'b0;
      lose           <= 1'b0;
      flags          <= '0;
      arm            <= '0;
      tx_begin       <= 1'b0;
      if (rx.strobe) begin
        if (is_step) begin
          send_start <= 1'b1;
          send_step  <= w.cmd.code[2:0];
        end else begin
          case (w.raw)
            CMD_PART_SYN: begin
              send_start        <= 1'b1;
              part_syn_start    <= 1'b1;
              send_step         <= '0;
              flags.coarse_data <= 1'b1;
            end
            CMD_FINE_DATA: begin
              send_start      <= 1'b1;
              flags.fine_data <= 1'b1;
            end
            CMD_DECODE_DATA: begin
              send_start        <= 1'b1;
              flags.decode_data <= 1'b1;
            end
            CMD_LOSE: lose <= 1'b1;
            CMD_COARSE_ARM: begin
              arm.coarse   <= 1'b1;
              flags.coarse <= 1'b1;
            end
            CMD_FINE_ARM: begin
              arm.fine   <= 1'b1;
              flags.fine <= 1'b1;
            end
            CMD_TX_BEGIN: begin
              tx_begin       <= 1'b1;
              flags.tx_data  <= 1'b1;
              dsp_start_send <= 1'b1;  // sticky until reset
            end
            default: ;  // plain payload, nothing to do
          endcase
        end
      end
    end
  end

endmodule

/* hdl/dsp_fpga_data.sv */
module dsp_fpga_data
  import mcbsp_link_pkg::*;
#(
  parameter int FRAME_WORDS = 40,
  parameter int BANK_BASE   = 6000,
  parameter int ADDR_W      = 14
) (
  input  logic              mcbsp0_slaver_clkx,
  input  logic              cfg_rst,
  input  logic              mcbsp0_slaver_fsx,
  input  logic              mcbsp0_slaver_mosi,
  input  logic [ADDR_W-1:0] read_addr,
  output logic              send_start,
  output step_t             send_step,
  output logic              part_syn_start,
  output logic              lose,
  output logic              dsp_start_send,
  output cmd_flags_t        flags,
  output logic              coarse_end,
  output logic              fine_end,
  output logic [31:0]       coarse_syn_pos,
  output logic [31:0]       fine_syn_pos,
  output logic              tx_send_start,
  output logic [31:0]       send_data
);

  rx_word_t  rx;        // word from the mcbsp0 slave
  sync_arm_t arm;
  logic      tx_begin;

  mcbsp_frame_rx u_frame_rx (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .fsx                (mcbsp0_slaver_fsx),
    .mosi               (mcbsp0_slaver_mosi),
    .rx                 (rx)
  );

  dsp_cmd_decode u_cmd_decode (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx                 (rx),
    .send_start         (send_start),
    .send_step          (send_step),
    .part_syn_start     (part_syn_start),
    .lose               (lose),
    .dsp_start_send     (dsp_start_send),
    .flags              (flags),
    .arm                (arm),
    .tx_begin           (tx_begin)
  );

  sync_pos_capture u_sync_capture (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx                 (rx),
    .arm                (arm),
    .coarse_syn_pos     (coarse_syn_pos),
    .fine_syn_pos       (fine_syn_pos),
    .coarse_end         (coarse_end),
    .fine_end           (fine_end)
  );

  pingpong_tx_buffer #(
    .FRAME_WORDS (FRAME_WORDS),
    .BANK_BASE   (BANK_BASE),
    .ADDR_W      (ADDR_W)
  ) u_tx_buffer (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx                 (rx),
    .tx_begin           (tx_begin),
    .read_addr          (read_addr),
    .send_data          (send_data),
    .tx_send_start      (tx_send_start)
  );

endmodule

/* hdl/mcbsp_frame_rx.sv */
module mcbsp_frame_rx
  import mcbsp_link_pkg::*;
(
  input  logic     mcbsp0_slaver_clkx,
  input  logic     cfg_rst,
  input  logic     fsx,
  input  logic     mosi,
  output rx_word_t rx
);

  logic [31:0] shreg;    // msb first
  logic [4:0]  bit_cnt;  // bits taken so far in this word
  logic        busy;
  logic        strobe;

  //////////////////////////////
  // serial shift
  //////////////////////////////

  // fsx edge carries the msb, so shift on it as well
  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if (fsx || busy) begin
      shreg <= {shreg[30:0], mosi};
    end
  end

  //////////////////////////////
  // bit count and word strobe
  //////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      strobe  <= 1'b0;
    end else begin
      strobe <= 1'b0;
      if (fsx) begin  // sync mid-word restarts
        busy    <= 1'b1;
        bit_cnt <= 5'd1;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 5'd1;
        if (bit_cnt == 5'd31) begin  // bit 0 lands on this edge
          busy   <= 1'b0;
          strobe <= 1'b1;
        end
      end
    end
  end

  // shreg is stable for the whole strobe cycle
  assign rx = {strobe, shreg};

endmodule

/* hdl/mcbsp_link_pkg.sv */
package mcbsp_link_pkg;

  //////////////////////////////
  // received word views
  //////////////////////////////

  typedef struct packed {
    logic [15:0] tag;   // upper half
    logic [15:0] code;  // lower half
  } cmd_fields_t;

  // one link word, read as payload or as a command
  typedef union packed {
    logic [31:0] raw;
    cmd_fields_t cmd;
  } dsp_word_u;

  typedef struct packed {
    logic      strobe;  // one cycle per complete word
    dsp_word_u word;
  } rx_word_t;

  //////////////////////////////
  // decoder side bundles
  //////////////////////////////

  typedef struct packed {
    logic coarse;
    logic fine;
    logic fine_data;
    logic decode_data;
    logic coarse_data;
    logic tx_data;
  } cmd_flags_t;

  typedef struct packed {
    logic coarse;
    logic fine;
  } sync_arm_t;

  typedef logic [2:0] step_t;  // steps 0..7

  // command codes from the dsp
  localparam logic [15:0] CMD_STEP_TAG    = 16'hAAAA;
  localparam logic [31:0] CMD_PART_SYN    = 32'hAAAA_AAAA;
  localparam logic [31:0] CMD_FINE_DATA   = 32'h6666_6666;
  localparam logic [31:0] CMD_DECODE_DATA = 32'h5555_5555;
  localparam logic [31:0] CMD_LOSE        = 32'h1111_1111;
  localparam logic [31:0] CMD_COARSE_ARM  = 32'h4444_4444;
  localparam logic [31:0] CMD_FINE_ARM    = 32'h3333_3333;
  localparam logic [31:0] CMD_TX_BEGIN    = 32'h6666_9999;

endpackage

/* hdl/pingpong_tx_buffer.sv */
module pingpong_tx_buffer
  import mcbsp_link_pkg::*;
#(
  parameter int FRAME_WORDS = 40,
  parameter int BANK_BASE   = 6000,
  parameter int ADDR_W      = 14
) (
  input  logic              mcbsp0_slaver_clkx,
  input  logic              cfg_rst,
  input  rx_word_t          rx,
  input  logic              tx_begin,
  input  logic [ADDR_W-1:0] read_addr,
  output logic [31:0]       send_data,
  output logic              tx_send_start
);

  localparam int IDX_W = $clog2(FRAME_WORDS);

  logic [31:0]       mem [2**ADDR_W];
  logic              frame_open;
  logic              bank;     // 0 -> base 0, 1 -> BANK_BASE
  logic [IDX_W-1:0]  wr_idx;
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_en;

  assign wr_en   = frame_open && rx.strobe;
  assign wr_addr = (bank ? ADDR_W'(BANK_BASE) : '0) + ADDR_W'(wr_idx);

  //////////////////////////////
  // frame state
  //////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      frame_open    <= 1'b0;
      bank          <= 1'b0;
      wr_idx        <= '0;
      tx_send_start <= 1'b0;
    end else begin
      tx_send_start <= 1'b0;
      if (!frame_open) begin
        if (tx_begin) begin  // ignored while a frame is open
          frame_open <= 1'b1;
          wr_idx     <= '0;
        end
      end else if (wr_en) begin
        if (wr_idx == IDX_W'(FRAME_WORDS - 1)) begin
          frame_open    <= 1'b0;
          tx_send_start <= 1'b1;
          bank          <= ~bank;  // next frame to the other bank
          wr_idx        <= '0;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // dual port ram
  //////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if (wr_en) mem[wr_addr] <= rx.word.raw;
    send_data <= mem[read_addr];  // one cycle read
  end

endmodule

/* hdl/sync_pos_capture.sv */
module sync_pos_capture
  import mcbsp_link_pkg::*;
(
  input  logic        mcbsp0_slaver_clkx,
  input  logic        cfg_rst,
  input  rx_word_t    rx,
  input  sync_arm_t   arm,
  output logic [31:0] coarse_syn_pos,
  output logic [31:0] fine_syn_pos,
  output logic        coarse_end,
  output logic        fine_end
);

  // bit 1 coarse, bit 0 fine
  logic [1:0] arm_v;
  logic [1:0] armed;
  logic [1:0] hit;

  assign arm_v = {arm.coarse, arm.fine};
  assign hit   = armed & {2{rx.strobe}};  // first word after arming

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      armed <= '0;
    end else begin
      armed <= (armed & ~hit) | arm_v;
    end
  end

  // channels are independent, one word may close both
  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      coarse_syn_pos <= '0;
      fine_syn_pos   <= '0;
      coarse_end     <= 1'b0;
      fine_end       <= 1'b0;
    end else begin
      coarse_end <= hit[1];
      fine_end   <= hit[0];
      if (hit[1]) coarse_syn_pos <= rx.word.raw;
      if (hit[0]) fine_syn_pos   <= rx.word.raw;
    end
  end

endmodule

/* project.f */
hdl/mcbsp_link_pkg.sv
hdl/mcbsp_frame_rx.sv
hdl/dsp_cmd_decode.sv
hdl/sync_pos_capture.sv
hdl/pingpong_tx_buffer.sv
hdl/dsp_fpga_data.sv
sim/tb_checker.sv
sim/tb_dsp_fpga_data.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, then look for the pass line in the run output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dsp_fpga_data -f project.f \
  && ./obj_dir/Vtb_dsp_fpga_data | tee /dev/stderr | grep -qx 'SIMULATION PASSED' \
  && echo 'run_sim: pass' \
  || { echo 'run_sim: fail'; exit 1; }

/* sim/tb_checker.sv */
module tb_checker
  import mcbsp_link_pkg::*;
#(
  parameter int FRAME_WORDS = 40,
  parameter int BANK_BASE   = 6000,
  parameter int ADDR_W      = 14
) (
  input logic              mcbsp0_slaver_clkx,
  input logic              cfg_rst,
  input logic              mcbsp0_slaver_fsx,
  input logic              mcbsp0_slaver_mosi,
  input logic [ADDR_W-1:0] read_addr,
  input logic [2:0]        test_id,
  input logic              send_start,
  input step_t             send_step,
  input logic              part_syn_start,
  input logic              lose,
  input logic              dsp_start_send,
  input cmd_flags_t        flags,
  input logic              coarse_end,
  input logic              fine_end,
  input logic [31:0]       coarse_syn_pos,
  input logic [31:0]       fine_syn_pos,
  input logic              tx_send_start,
  input logic [31:0]       send_data
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic       send_start;
    logic       part_syn;
    logic       lose;
    logic       step_ld;   // step register reloads
    step_t      step;
    logic       arm_c;
    logic       arm_f;
    logic       tx_begin;
    cmd_flags_t flags;
  } dec_exp_t;

  string test_names [7] = '{"reset", "steps", "commands", "capture",
                            "frame_bank0", "frame_bank1", "readback"};

  int          errors = 0;
  int          words_checked = 0;
  int          read_checks = 0;
  int          bit_cnt = 0;  // 0 means idle
  logic [31:0] sh;
  logic [31:0] chk_word;
  logic        word_ready = 1'b0;
  logic        check_now = 1'b0;
  logic [ADDR_W-1:0] rd_q = '0;
  logic [2:0]  test_q = '0;
  dec_exp_t    ex;

  // reference state
  step_t       step_m = '0;
  logic        start_m = 1'b0;
  logic        armed_c = 1'b0;
  logic        armed_f = 1'b0;
  logic        c_hit;
  logic        f_hit;
  logic [31:0] cpos_m = '0;
  logic [31:0] fpos_m = '0;
  logic        open_m = 1'b0;
  logic        bank_m = 1'b0;
  int          idx_m = 0;
  logic        tx_done;
  bit [31:0]   image [int];  // buffer image by address

  //////////////////////////////
  // decode table
  //////////////////////////////

  function automatic dec_exp_t decode_ref(input logic [31:0] w);
    dec_exp_t   e;
    logic [3:0] n;
    int         i;
    e = '0;
    for (i = 0; i < 8; i++) begin
      n = 4'(i);
      if (w == {CMD_STEP_TAG, n, n, n, n}) begin
        e.send_start = 1'b1;
        e.step_ld    = 1'b1;
        e.step       = n[2:0];
      end
    end
    case (w)
      CMD_PART_SYN: begin
        e.send_start        = 1'b1;
        e.part_syn          = 1'b1;
        e.step_ld           = 1'b1;  // back to step 0
        e.flags.coarse_data = 1'b1;
      end
      CMD_FINE_DATA: begin
        e.send_start      = 1'b1;
        e.flags.fine_data = 1'b1;
      end
      CMD_DECODE_DATA: begin
        e.send_start        = 1'b1;
        e.flags.decode_data = 1'b1;
      end
      CMD_LOSE: e.lose = 1'b1;
      CMD_COARSE_ARM: begin
        e.arm_c        = 1'b1;
        e.flags.coarse = 1'b1;
      end
      CMD_FINE_ARM: begin
        e.arm_f      = 1'b1;
        e.flags.fine = 1'b1;
      end
      CMD_TX_BEGIN: begin
        e.tx_begin      = 1'b1;
        e.flags.tx_data = 1'b1;
      end
      default: ;
    endcase
    return e;
  endfunction

  task automatic compare_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH [%s] %s expected %h actual %h", test_names[test_q], sig, exp, act);
    end
  endtask

  task automatic compare_pulse(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      if (exp) $display("MISMATCH [%s] %s expected 1 actual %b", test_names[test_q], sig, act);
      else $display("[%s] %s pulsed with no command asking for it, at %0t ns",
                    test_names[test_q], sig, $time);
    end
  endtask

  //////////////////////////////
  // word rebuild
  //////////////////////////////

  always @(posedge mcbsp0_slaver_clkx) begin
    check_now  = word_ready;  // outputs due one edge after bit 0
    word_ready = 1'b0;
    rd_q       = read_addr;
    test_q     = test_id;
    if (mcbsp0_slaver_fsx) begin
      sh      = {31'd0, mcbsp0_slaver_mosi};
      bit_cnt = 1;
    end else if (bit_cnt != 0) begin
      sh      = {sh[30:0], mcbsp0_slaver_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 32) begin
        chk_word   = sh;
        word_ready = 1'b1;
        bit_cnt    = 0;
      end
    end
  end

  // outputs settle by the falling edge
  always @(negedge mcbsp0_slaver_clkx) begin
    if (!cfg_rst) begin
      if (image.exists(int'(rd_q))) begin  // old data on a same-edge write
        compare_val("send_data", image[int'(rd_q)], send_data);
        read_checks++;
      end
      ex      = check_now ? decode_ref(chk_word) : '0;
      c_hit   = check_now && armed_c;
      f_hit   = check_now && armed_f;
      tx_done = 1'b0;
      if (ex.step_ld) step_m = ex.step;
      if (ex.tx_begin) start_m = 1'b1;
      if (c_hit) cpos_m = chk_word;
      if (f_hit) fpos_m = chk_word;
      if (check_now) begin
        words_checked++;
        armed_c = ex.arm_c;  // hit clears, arm word sets
        armed_f = ex.arm_f;
        if (open_m) begin
          image[bank_m ? BANK_BASE + idx_m : idx_m] = chk_word;
          idx_m++;
          if (idx_m == FRAME_WORDS) begin
            tx_done = 1'b1;
            open_m  = 1'b0;
            bank_m  = !bank_m;
            idx_m   = 0;
          end
        end else if (ex.tx_begin) begin
          open_m = 1'b1;
        end
      end
      compare_pulse("send_start", ex.send_start, send_start);
      compare_pulse("part_syn_start", ex.part_syn, part_syn_start);
      compare_pulse("lose", ex.lose, lose);
      compare_pulse("coarse_end", c_hit, coarse_end);
      compare_pulse("fine_end", f_hit, fine_end);
      compare_pulse("tx_send_start", tx_done, tx_send_start);
      compare_val("flags", {26'd0, ex.flags}, {26'd0, flags});
      compare_val("send_step", {29'd0, step_m}, {29'd0, send_step});
      compare_val("dsp_start_send", {31'd0, start_m}, {31'd0, dsp_start_send});
      compare_val("coarse_syn_pos", cpos_m, coarse_syn_pos);
      compare_val("fine_syn_pos", fpos_m, fine_syn_pos);
    end
  end

endmodule

/* sim/tb_dsp_fpga_data.sv */
module tb_dsp_fpga_data
  import mcbsp_link_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_WORDS = 40;
  localparam int BANK_BASE   = 6000;
  localparam int ADDR_W      = 14;
  localparam int N_WORDS     = 101;  // every word sent below
  localparam int WATCHDOG_NS = N_WORDS * 36 * 100 + 10_000;

  logic              mcbsp0_slaver_clkx;
  logic              cfg_rst;
  logic              mcbsp0_slaver_fsx;
  logic              mcbsp0_slaver_mosi;
  logic [ADDR_W-1:0] read_addr;
  logic [2:0]        test_id;
  logic              send_start;
  step_t             send_step;
  logic              part_syn_start;
  logic              lose;
  logic              dsp_start_send;
  cmd_flags_t        flags;
  logic              coarse_end;
  logic              fine_end;
  logic [31:0]       coarse_syn_pos;
  logic [31:0]       fine_syn_pos;
  logic              tx_send_start;
  logic [31:0]       send_data;

  dsp_fpga_data #(
    .FRAME_WORDS (FRAME_WORDS),
    .BANK_BASE   (BANK_BASE),
    .ADDR_W      (ADDR_W)
  ) dut (.*);

  tb_checker #(
    .FRAME_WORDS (FRAME_WORDS),
    .BANK_BASE   (BANK_BASE),
    .ADDR_W      (ADDR_W)
  ) u_checker (.*);

  initial begin
    mcbsp0_slaver_clkx = 1'b0;
    forever #50 mcbsp0_slaver_clkx = ~mcbsp0_slaver_clkx;
  end

  // msb first, fsx with the msb, then 2 idle cycles
  task automatic send_word(input logic [31:0] w);
    int i;
    for (i = 31; i >= 0; i--) begin
      @(negedge mcbsp0_slaver_clkx);
      mcbsp0_slaver_fsx  = (i == 31);
      mcbsp0_slaver_mosi = w[i];
    end
    @(negedge mcbsp0_slaver_clkx);
    mcbsp0_slaver_mosi = 1'b0;
    @(negedge mcbsp0_slaver_clkx);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    int i;
    int seq_errors;
    seq_errors         = 0;
    cfg_rst            = 1'b1;
    mcbsp0_slaver_fsx  = 1'b0;
    mcbsp0_slaver_mosi = 1'b0;
    read_addr          = '0;
    test_id            = 3'd0;
    void'($urandom(32'h82bb4788));
    repeat (10) @(negedge mcbsp0_slaver_clkx);
    cfg_rst = 1'b0;

    test_id = 3'd1;
    for (i = 0; i < 8; i++) send_word({CMD_STEP_TAG, {4{4'(i)}}});
    send_word($urandom);  // step 7 must hold
    send_word($urandom);

    test_id = 3'd2;
    send_word(CMD_PART_SYN);
    send_word(CMD_FINE_DATA);
    send_word(CMD_DECODE_DATA);
    send_word(CMD_LOSE);
    send_word($urandom);

    test_id = 3'd3;
    send_word(CMD_COARSE_ARM);
    send_word($urandom);
    send_word(CMD_FINE_ARM);
    send_word($urandom);

    test_id = 3'd4;
    send_word(CMD_TX_BEGIN);
    for (i = 0; i < FRAME_WORDS; i++) send_word($urandom);

    // second frame, with commands mixed into the payload
    test_id = 3'd5;
    send_word(CMD_TX_BEGIN);
    for (i = 0; i < FRAME_WORDS; i++) begin
      case (i)
        3:       send_word(CMD_LOSE);
        7:       send_word({CMD_STEP_TAG, 16'h5555});
        11:      send_word(CMD_TX_BEGIN);
        default: send_word($urandom);
      endcase
    end

    test_id = 3'd6;
    for (i = 0; i < 2 * FRAME_WORDS; i++) begin
      @(negedge mcbsp0_slaver_clkx);
      read_addr = ADDR_W'(i < FRAME_WORDS ? i : BANK_BASE + i - FRAME_WORDS);
    end
    repeat (3) @(negedge mcbsp0_slaver_clkx);
    @(posedge mcbsp0_slaver_clkx);  // checker counts are settled here

    if (u_checker.words_checked != N_WORDS) begin
      $display("checker rebuilt %0d words but %0d were sent", u_checker.words_checked, N_WORDS);
      seq_errors++;
    end
    $display("errors: %0d (checker %0d, sequence %0d), words %0d, reads %0d",
             u_checker.errors + seq_errors, u_checker.errors, seq_errors,
             u_checker.words_checked, u_checker.read_checks);
    if (u_checker.errors + seq_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the sequence did not finish", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
